/* common/juart_config.svh */
`ifndef JUART_CONFIG_SVH
`define JUART_CONFIG_SVH

// ==========================================================================
// Console FIFO sizing
// ==========================================================================
`define JUART_FIFO_AW    4              // 16 byte queue

// ==========================================================================
// Instruction register and ID code
// ==========================================================================
`define JUART_IR_W       4
`define JUART_IR_IDCODE  4'h2
`define JUART_IR_USER1   4'h8           // Console data register
`define JUART_IR_BYPASS  4'hF           // Any unknown code acts the same
`define JUART_IDCODE     32'h0A51_C0DB  // Marker bit 0 must be 1

`endif

/* common/juart_pkg.sv */
`default_nettype none

package juart_pkg;

`include "juart_config.svh"

    // IEEE 1149.1 state encodings
    typedef enum logic [3:0] {
        TAP_RESET      = 4'hF,
        TAP_IDLE       = 4'hC,
        TAP_SELECT_DR  = 4'h7,
        TAP_CAPTURE_DR = 4'h6,
        TAP_SHIFT_DR   = 4'h2,
        TAP_EXIT1_DR   = 4'h1,
        TAP_PAUSE_DR   = 4'h3,
        TAP_EXIT2_DR   = 4'h0,
        TAP_UPDATE_DR  = 4'h5,
        TAP_SELECT_IR  = 4'h4,
        TAP_CAPTURE_IR = 4'hE,
        TAP_SHIFT_IR   = 4'hA,
        TAP_EXIT1_IR   = 4'h9,
        TAP_PAUSE_IR   = 4'hB,
        TAP_EXIT2_IR   = 4'h8,
        TAP_UPDATE_IR  = 4'hD
    } tap_state_e;

    // ======================================================================
    // Shared 32-bit shift word, decoded by the current instruction
    // ======================================================================
    typedef struct packed {
        logic [3:0]  version;
        logic [15:0] part;
        logic [10:0] manufacturer;
        logic        marker;                // Always 1 per 1149.1
    } idcode_view_t;

    typedef struct packed {
        logic [21-`JUART_FIFO_AW:0] reserved;   // Reads as zero
        logic [`JUART_FIFO_AW:0]    level;      // Fill level before pop
        logic                       valid;      // Data byte is real
        logic [7:0]                 data;       // Shifted out first
    } console_view_t;

    typedef union packed {
        idcode_view_t  idcode;
        console_view_t console;
    } jtag_dr_u;

endpackage

`default_nettype wire

/* common/fifo_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "juart_config.svh"

// Read side of the console FIFO, seen by the JTAG data register
interface fifo_rd_if;

    logic [7:0]              rd_data;   // Head byte, valid when not empty
    logic                    empty;
    logic [`JUART_FIFO_AW:0] level;     // 0 .. depth
    logic                    pop;       // Drops head on this edge

    modport fifo_side (
        output rd_data, empty, level,
        input  pop
    );

    modport dr_side (
        input  rd_data, empty, level,
        output pop
    );

endinterface

`default_nettype wire

/* logic/host_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack write port into the console FIFO
module host_write_port (
    input  wire        tck,
    input  wire        rst_n,
    // Host side
    input  wire        i_wr_req,
    input  wire  [7:0] i_wr_data,
    output logic       o_wr_ack,
    // FIFO side
    output logic       o_push,
    output logic [7:0] o_push_data,
    input  wire        i_full
);

    // ======================================================================
    // Handshake
    // ======================================================================
    logic accept;                       // Byte taken on this edge

    // Only while ack is low, so one push per request phase
    assign accept = i_wr_req & ~o_wr_ack & ~i_full;

    assign o_push      = accept;
    assign o_push_data = i_wr_data;     // Host holds it stable under req

    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            o_wr_ack <= 1'b0;
        end else if (accept) begin
            o_wr_ack <= 1'b1;           // Phase 2, byte is in
        end else if (!i_wr_req) begin
            o_wr_ack <= 1'b0;           // Phase 4, back to idle
        end
    end

    // Full FIFO just leaves ack low
    // Host keeps req and data up until a slot frees

endmodule

`default_nettype wire

/* logic/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "juart_config.svh"

// Single-clock byte queue between host port and JTAG console register
module byte_fifo (
    input  wire        tck,
    input  wire        rst_n,
    input  wire        i_push,
    input  wire  [7:0] i_push_data,
    output logic       o_full,
    fifo_rd_if.fifo_side rd
);

    localparam int AW    = `JUART_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    // ======================================================================
    // Storage and pointers
    // ======================================================================
    logic [7:0] mem [DEPTH];
    logic [AW:0] wr_ptr;                // Extra bit tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;
    logic        ptr_match;

    assign ptr_match = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rd.empty  = ptr_match && (wr_ptr[AW] == rd_ptr[AW]);
    assign o_full    = ptr_match && (wr_ptr[AW] != rd_ptr[AW]);
    assign rd.level  = wr_ptr - rd_ptr;                 // Wraps cleanly

    // Illegal requests dropped here
    assign do_push = i_push & ~o_full;
    assign do_pop  = rd.pop & ~rd.empty;

    always_ff @(posedge tck) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= i_push_data;
        end
    end

    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;    // Push+pop leaves level as is
            end
        end
    end

    // Head byte, async read
    assign rd.rd_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

/* jtag_tap/jtag_tap_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

// IEEE 1149.1 test access port controller
module jtag_tap_fsm
    import juart_pkg::*;
(
    input  wire        tck,
    input  wire        rst_n,
    input  wire        i_tms,
    output tap_state_e o_state
);

    tap_state_e state_q;
    tap_state_e state_d;

    // ======================================================================
    // Transition table, TMS sampled on rising tck
    // ======================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            TAP_RESET:      state_d = i_tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_d = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            // DR column
            TAP_SELECT_DR:  state_d = i_tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_d = i_tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_d = i_tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_d = i_tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_d = i_tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_d = i_tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_d = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            // IR column
            TAP_SELECT_IR:  state_d = i_tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_d = i_tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_d = i_tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_d = i_tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_d = i_tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_d = i_tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_d = i_tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_d = TAP_RESET;    // All 16 codes used anyway
        endcase
    end

    // Five TMS-high edges reach Test-Logic-Reset from anywhere
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TAP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_state = state_q;

endmodule

`default_nettype wire

/* jtag_tap/jtag_console_dr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "juart_config.svh"

// Instruction register, data registers and TDO path of the console TAP
module jtag_console_dr
    import juart_pkg::*;
(
    input  wire        tck,
    input  wire        rst_n,
    input  wire        i_tdi,
    input  tap_state_e i_state,
    output logic       o_tdo,
    output logic       o_tdo_en,
    fifo_rd_if.dr_side rd
);

    localparam int IRW = `JUART_IR_W;

    logic [IRW-1:0] ir_sh;          // IR shift stage
    logic [IRW-1:0] ir_q;           // Active instruction
    logic           bypass_q;
    jtag_dr_u       dr_q;           // Shared shift word
    jtag_dr_u       frame_c;        // Console frame to capture
    logic           cap_valid;      // Valid bit as captured
    logic           sel_idcode;
    logic           sel_user1;

    assign sel_idcode = (ir_q == `JUART_IR_IDCODE);
    assign sel_user1  = (ir_q == `JUART_IR_USER1);

    // ======================================================================
    // Instruction register
    // ======================================================================
    always_ff @(posedge tck) begin
        if (i_state == TAP_CAPTURE_IR) begin
            ir_sh <= {{(IRW-1){1'b0}}, 1'b1};       // 0001 capture pattern
        end else if (i_state == TAP_SHIFT_IR) begin
            ir_sh <= {i_tdi, ir_sh[IRW-1:1]};       // LSB out first
        end
    end

    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            ir_q <= `JUART_IR_IDCODE;
        end else if (i_state == TAP_RESET) begin
            ir_q <= `JUART_IR_IDCODE;
        end else if (i_state == TAP_UPDATE_IR) begin
            ir_q <= ir_sh;
        end
    end

    // ======================================================================
    // Data registers
    // ======================================================================
    always_comb begin
        frame_c                  = '0;
        frame_c.console.level    = rd.level;
        frame_c.console.valid    = ~rd.empty;
        frame_c.console.data     = rd.empty ? 8'h00 : rd.rd_data;  // Zero when empty
    end

    always_ff @(posedge tck) begin
        if (i_state == TAP_CAPTURE_DR) begin
            bypass_q <= 1'b0;
            if (sel_idcode) begin
                dr_q.idcode <= `JUART_IDCODE;
            end else if (sel_user1) begin
                dr_q <= frame_c;
            end
        end else if (i_state == TAP_SHIFT_DR) begin
            bypass_q <= i_tdi;                      // One bit delay
            if (sel_idcode || sel_user1) begin
                dr_q <= {i_tdi, dr_q[31:1]};
            end
        end
    end

    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else if (i_state == TAP_CAPTURE_DR) begin
            cap_valid <= sel_user1 & ~rd.empty;
        end
    end

    // Head leaves the FIFO only if the probe actually saw it
    assign rd.pop = (i_state == TAP_UPDATE_DR) && sel_user1 && cap_valid;

    // ======================================================================
    // TDO mux
    // ======================================================================
    assign o_tdo_en = (i_state == TAP_SHIFT_DR) || (i_state == TAP_SHIFT_IR);

    always_comb begin
        o_tdo = 1'b0;
        if (i_state == TAP_SHIFT_IR) begin
            o_tdo = ir_sh[0];
        end else if (i_state == TAP_SHIFT_DR) begin
            if (sel_idcode || sel_user1) begin
                o_tdo = dr_q[0];                    // Bit 0 of the shift word
            end else begin
                o_tdo = bypass_q;                   // Bypass and unknown codes
            end
        end
    end

endmodule

`default_nettype wire

/* logic/jtag_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

// JTAG console transmitter, host bytes out through USER1
module jtag_uart_top
    import juart_pkg::*;
(
    input  wire        tck,
    input  wire        rst_n,
    // JTAG pins, TDO with separate enable
    input  wire        i_tms,
    input  wire        i_tdi,
    output logic       o_tdo,
    output logic       o_tdo_en,
    // Host write port
    input  wire        i_wr_req,
    input  wire  [7:0] i_wr_data,
    output logic       o_wr_ack
);

    logic       push;
    logic [7:0] push_data;
    logic       full;
    tap_state_e tap_state;

    fifo_rd_if u_rd_bus ();

    host_write_port u_host_port (
        .tck         (tck),
        .rst_n       (rst_n),
        .i_wr_req    (i_wr_req),
        .i_wr_data   (i_wr_data),
        .o_wr_ack    (o_wr_ack),
        .o_push      (push),
        .o_push_data (push_data),
        .i_full      (full)
    );

    byte_fifo u_fifo (
        .tck         (tck),
        .rst_n       (rst_n),
        .i_push      (push),
        .i_push_data (push_data),
        .o_full      (full),
        .rd          (u_rd_bus.fifo_side)
    );

    jtag_tap_fsm u_tap (
        .tck     (tck),
        .rst_n   (rst_n),
        .i_tms   (i_tms),
        .o_state (tap_state)
    );

    jtag_console_dr u_dr (
        .tck      (tck),
        .rst_n    (rst_n),
        .i_tdi    (i_tdi),
        .i_state  (tap_state),
        .o_tdo    (o_tdo),
        .o_tdo_en (o_tdo_en),
        .rd       (u_rd_bus.dr_side)
    );

endmodule

`default_nettype wire

/* bench/jtag_uart_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake and TDO enable properties, bound into the top level
module jtag_uart_asserts
    import juart_pkg::*;
(
    input wire        tck,
    input wire        rst_n,
    input wire        i_tms,
    input wire        i_wr_req,
    input wire        i_wr_ack,
    input wire        i_tdo_en,
    input tap_state_e i_state
);

    int n_fail = 0;                     // Summed into the closing line

    // ======================================================================
    // Four-phase host port
    // ======================================================================
    ack_needs_req: assert property (@(posedge tck) disable iff (!rst_n)
        $rose(i_wr_ack) |-> $past(i_wr_req))
        else begin
            n_fail++;
            $error("o_wr_ack rose without i_wr_req");
        end

    // Ack may only drop once req is gone
    ack_falls_after_req: assert property (@(posedge tck) disable iff (!rst_n)
        $fell(i_wr_ack) |-> !$past(i_wr_req))
        else begin
            n_fail++;
            $error("o_wr_ack fell while i_wr_req was still high");
        end

    // TDO driver on only after a TMS-low step into a shift state
    tdo_en_in_shift: assert property (@(posedge tck) disable iff (!rst_n)
        i_tdo_en |-> !$past(i_tms) && ($past(i_state) inside {
            TAP_CAPTURE_DR, TAP_SHIFT_DR, TAP_EXIT2_DR,
            TAP_CAPTURE_IR, TAP_SHIFT_IR, TAP_EXIT2_IR}))
        else begin
            n_fail++;
            $error("o_tdo_en high without a TMS-low step into Shift-DR or Shift-IR");
        end

endmodule

bind jtag_uart_top jtag_uart_asserts u_asserts (
    .tck      (tck),
    .rst_n    (rst_n),
    .i_tms    (i_tms),
    .i_wr_req (i_wr_req),
    .i_wr_ack (o_wr_ack),
    .i_tdo_en (o_tdo_en),
    .i_state  (tap_state)
);

`default_nettype wire

/* bench/jtag_uart_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "juart_config.svh"

// Reference TAP, IR and byte queue, fed from the top-level pins only
module jtag_uart_checker
    import juart_pkg::*;
(
    input  wire       tck,
    input  wire       rst_n,
    input  wire       i_tms,
    input  wire       i_tdi,
    input  wire       i_tdo,
    input  wire       i_tdo_en,
    input  wire       i_wr_ack,
    input  wire [7:0] i_wr_data,
    output int        o_errors,
    output int        o_scans
);

    localparam int IRW   = `JUART_IR_W;
    localparam int LW    = `JUART_FIFO_AW + 1;
    localparam int DEPTH = 1 << `JUART_FIFO_AW;

    tap_state_e  st = TAP_RESET;
    logic [3:0]  ir = `JUART_IR_IDCODE;
    logic [31:0] sh;                    // Model of the selected register
    int          sh_w;                  // Its length
    logic [31:0] exp_bits;
    logic [31:0] act_bits;
    int          nbits;
    logic        cap_valid = 1'b0;
    logic        ack_q = 1'b0;
    logic [7:0]  q[$];                  // Bytes the probe has not popped yet
    jtag_dr_u    frame;
    int          errors = 0;
    int          scans = 0;

    assign o_errors = errors;
    assign o_scans  = scans;

    // IEEE 1149.1 state diagram
    function automatic tap_state_e tap_next(input tap_state_e s, input logic tms);
        case (s)
            TAP_RESET:      return tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       return tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  return tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: return tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   return tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   return tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   return tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   return tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_SELECT_IR:  return tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: return tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   return tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   return tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   return tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   return tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            default:        return tms ? TAP_SELECT_DR : TAP_IDLE;  // Both Update states
        endcase
    endfunction

    always @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            st        = TAP_RESET;
            ir        = `JUART_IR_IDCODE;
            cap_valid = 1'b0;
            ack_q     = 1'b0;
            q.delete();
        end else begin
            // Byte enters on the rising ack, data still held by the host
            if (i_wr_ack && !ack_q) begin
                if (q.size() >= DEPTH) begin
                    errors++;
                    $display("o_wr_ack rose although the FIFO model was already full");
                end else begin
                    q.push_back(i_wr_data);
                end
            end
            ack_q = i_wr_ack;

            if (i_tdo_en !== (st == TAP_SHIFT_DR || st == TAP_SHIFT_IR)) begin
                errors++;
                $display("FAIL o_tdo_en expected %h actual %h",
                         st == TAP_SHIFT_DR || st == TAP_SHIFT_IR, i_tdo_en);
            end

            case (st)
                TAP_RESET: ir = `JUART_IR_IDCODE;
                TAP_CAPTURE_IR: begin
                    sh    = 32'h1;      // 0001 pattern
                    sh_w  = IRW;
                    nbits = 0;
                end
                TAP_CAPTURE_DR: begin
                    nbits     = 0;
                    cap_valid = (ir == `JUART_IR_USER1) && (q.size() != 0);
                    if (ir == `JUART_IR_IDCODE) begin
                        sh   = `JUART_IDCODE;
                        sh_w = 32;
                    end else if (ir == `JUART_IR_USER1) begin
                        frame               = '0;
                        frame.console.level = LW'(q.size());   // Level before pop
                        frame.console.valid = (q.size() != 0);
                        frame.console.data  = (q.size() != 0) ? q[0] : 8'h00;
                        sh   = frame;
                        sh_w = 32;
                    end else begin
                        sh   = 32'h0;           // Bypass, one stage
                        sh_w = 1;
                    end
                end
                TAP_SHIFT_DR, TAP_SHIFT_IR: begin
                    if (nbits == 0) begin
                        exp_bits = '0;
                        act_bits = '0;
                    end
                    if (nbits < 32) begin
                        exp_bits[nbits] = sh[0];
                        act_bits[nbits] = i_tdo;
                    end
                    nbits++;
                    sh           = sh >> 1;
                    sh[sh_w - 1] = i_tdi;
                    if (i_tms) begin            // Last bit of this scan
                        scans++;
                        if (act_bits !== exp_bits) begin
                            errors++;
                            $display("FAIL o_tdo scan %0d expected %h actual %h",
                                     scans, exp_bits, act_bits);
                        end
                    end
                end
                TAP_UPDATE_IR: ir = sh[IRW-1:0];
                TAP_UPDATE_DR: begin
                    if (ir == `JUART_IR_USER1 && cap_valid) begin
                        void'(q.pop_front());
                    end
                end
                default: ;
            endcase
            st = tap_next(st, i_tms);
        end
    end

endmodule

`default_nettype wire

/* bench/jtag_uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "juart_config.svh"

module jtag_uart_tb;

    localparam int IRW        = `JUART_IR_W;
    localparam int DEPTH      = 1 << `JUART_FIFO_AW;
    localparam int N_SCANS    = 60;
    localparam int SCAN_LEN   = 45;
    localparam int N_WRITES   = 2 * DEPTH + 1;
    localparam int WRITE_LEN  = 8;      // Gap plus the four phases
    localparam int MAX_CYCLES = 2 * (N_SCANS * SCAN_LEN + N_WRITES * WRITE_LEN) + 16;

    logic        tck = 1'b0;
    logic        rst_n;
    logic        tms;
    logic        tdi;
    logic        wr_req;
    logic [7:0]  wr_data;
    wire         tdo;
    wire         tdo_en;
    wire         wr_ack;
    logic [15:0] lfsr = 16'd18899;
    int          cycles = 0;
    int          errors = 0;
    int          scans_run = 0;
    int          chk_errors;
    int          chk_scans;

    always #4 tck = ~tck;

    jtag_uart_top dut (
        .tck      (tck),      .rst_n     (rst_n),
        .i_tms    (tms),      .i_tdi     (tdi),
        .o_tdo    (tdo),      .o_tdo_en  (tdo_en),
        .i_wr_req (wr_req),   .i_wr_data (wr_data),
        .o_wr_ack (wr_ack)
    );

    jtag_uart_checker u_checker (
        .tck       (tck),     .rst_n     (rst_n),
        .i_tms     (tms),     .i_tdi     (tdi),
        .i_tdo     (tdo),     .i_tdo_en  (tdo_en),
        .i_wr_ack  (wr_ack),  .i_wr_data (wr_data),
        .o_errors  (chk_errors),
        .o_scans   (chk_scans)
    );

    // ======================================================================
    // Random bits and pin drivers
    // ======================================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // Galois, taps 16 14 13 11
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    task automatic jtag_cycle(input logic tms_v, input logic tdi_v);
        @(posedge tck);
        tms <= tms_v;
        tdi <= tdi_v;
    endtask

    // From Idle back to Idle, random TDI, sometimes through Pause-DR
    task automatic dr_scan(input int n);
        logic [7:0] r;
        scans_run++;
        jtag_cycle(1'b1, 1'b0);             // Select-DR
        jtag_cycle(1'b0, 1'b0);             // Capture-DR
        jtag_cycle(1'b0, 1'b0);
        for (int i = 0; i < n; i++) begin
            take_bits(1, r);
            jtag_cycle(i == n - 1, r[0]);
        end
        take_bits(1, r);
        if (r[0]) begin
            jtag_cycle(1'b0, 1'b0);         // Pause-DR
            jtag_cycle(1'b1, 1'b0);         // Exit2-DR
        end
        jtag_cycle(1'b1, 1'b0);             // Update-DR
        jtag_cycle(1'b0, 1'b0);
    endtask

    task automatic ir_scan(input logic [3:0] code);
        scans_run++;
        jtag_cycle(1'b1, 1'b0);
        jtag_cycle(1'b1, 1'b0);             // Select-IR
        jtag_cycle(1'b0, 1'b0);             // Capture-IR
        jtag_cycle(1'b0, 1'b0);
        for (int i = 0; i < IRW; i++) begin
            jtag_cycle(i == IRW - 1, code[i]);  // LSB first
        end
        jtag_cycle(1'b1, 1'b0);             // Update-IR
        jtag_cycle(1'b0, 1'b0);
    endtask

    task automatic start_write(input logic [7:0] data);
        @(posedge tck);
        wr_req  <= 1'b1;
        wr_data <= data;
    endtask

    task automatic finish_write();
        @(negedge tck);
        while (!wr_ack) @(negedge tck);
        @(posedge tck);
        wr_req <= 1'b0;
        @(negedge tck);
        while (wr_ack) @(negedge tck);      // Phase 4 done
    endtask

    task automatic write_random();
        logic [7:0] r;
        take_bits(2, r);
        repeat (r) @(posedge tck);          // Gap of 0 to 3 cycles
        take_bits(8, r);
        start_write(r);
        finish_write();
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        logic [7:0] n;
        rst_n   = 1'b0;
        tms     = 1'b1;
        tdi     = 1'b0;
        wr_req  = 1'b0;
        wr_data = 8'h00;
        repeat (16) @(posedge tck);
        rst_n <= 1'b1;
        jtag_cycle(1'b0, 1'b0);             // Test-Logic-Reset to Idle

        dr_scan(32);                        // ID code after reset

        ir_scan(`JUART_IR_BYPASS);
        dr_scan(32);
        ir_scan(4'h5);                      // Unassigned, acts as bypass
        dr_scan(32);

        // Random writes and USER1 reads, at most 12 left behind
        ir_scan(`JUART_IR_USER1);
        repeat (4) begin
            take_bits(2, n);
            repeat (n + 1) write_random();
            take_bits(2, n);
            repeat (n + 1) dr_scan(32);
        end
        repeat (14) dr_scan(32);            // Last two see an empty FIFO

        // Fill up, the 17th request waits for one pop
        repeat (DEPTH) write_random();
        take_bits(8, n);
        start_write(n);
        repeat (8) @(negedge tck);
        dr_scan(32);
        finish_write();
        repeat (DEPTH + 1) dr_scan(32);

        // Abort a DR shift with five TMS-high edges
        scans_run++;
        jtag_cycle(1'b1, 1'b0);
        jtag_cycle(1'b0, 1'b0);
        jtag_cycle(1'b0, 1'b0);
        repeat (5) jtag_cycle(1'b0, 1'b1);
        repeat (5) jtag_cycle(1'b1, 1'b0);
        jtag_cycle(1'b0, 1'b0);
        dr_scan(32);                        // ID code again

        repeat (4) @(posedge tck);
        @(negedge tck);
        if (chk_scans != scans_run) begin
            errors++;
            $display("checker compared %0d scans but the bench ran %0d", chk_scans, scans_run);
        end
        $display("errors: checker %0d, bench %0d, assertions %0d",
                 chk_errors, errors, dut.u_asserts.n_fail);
        if (chk_errors + errors + dut.u_asserts.n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/juart_pkg.sv
common/fifo_rd_if.sv
logic/host_write_port.sv
logic/byte_fifo.sv
jtag_tap/jtag_tap_fsm.sv
jtag_tap/jtag_console_dr.sv
logic/jtag_uart_top.sv
bench/jtag_uart_asserts.sv
bench/jtag_uart_checker.sv
bench/jtag_uart_tb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module jtag_uart_tb -f all.f -o jtag_uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/jtag_uart_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
